// File: slide_consts.svh
// Sizing macros of the slide unit, included by the package and by every RTL module
`ifndef SLIDE_CONSTS_SVH
`define SLIDE_CONSTS_SVH

////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////

// Number of lanes, each delivers one word per operand beat
`define SLIDE_NR_LANES 4

// Bytes in one lane word (64-bit lanes)
`define SLIDE_LANE_BYTES 8

////////////////////////////////////////
// Queue sizes
////////////////////////////////////////

// Instructions in flight between accept and commit
`define SLIDE_INSN_DEPTH 2

// Destination words waiting for the lane grants
`define SLIDE_RESULT_DEPTH 2

////////////////////////////////////////
// Field widths
////////////////////////////////////////

`define SLIDE_ID_W 3
`define SLIDE_ADDR_W 8

// Up to 256 bytes per vector register, so 8 destination words
`define SLIDE_BYTE_CNT_W 9

`endif

// File: slide_pkg.sv
// Types shared by the slide unit modules, imported by wildcard in each module header
`default_nettype none

`include "slide_consts.svh"

package slide_pkg;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  // One lane word
  typedef logic [8*`SLIDE_LANE_BYTES-1:0] lane_data_t;
  // Byte enables of one lane word
  typedef logic [`SLIDE_LANE_BYTES-1:0]   lane_strb_t;
  // Word address into the register file
  typedef logic [`SLIDE_ADDR_W-1:0]       vaddr_t;
  // Instruction tag handed out by the sequencer
  typedef logic [`SLIDE_ID_W-1:0]         insn_id_t;
  // Byte count, or byte offset inside a vector register
  typedef logic [`SLIDE_BYTE_CNT_W-1:0]   byte_cnt_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic {
    VSLIDEUP,
    VSLIDEDOWN
  } slide_op_e;

  // Element width, also the left shift from elements to bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } sew_e;

  // Slide request from the sequencer
  // vl and stride count elements, not bytes
  typedef struct packed {
    insn_id_t  id;
    slide_op_e op;
    sew_e      sew;
    byte_cnt_t vl;
    byte_cnt_t stride;
    vaddr_t    vd;
  } slide_req_t;

  // Full vector register word, lane 0 in the low bits
  typedef lane_data_t [`SLIDE_NR_LANES-1:0] vec_word_t;
  typedef lane_strb_t [`SLIDE_NR_LANES-1:0] vec_strb_t;

  // Destination word on its way to the register file
  typedef struct packed {
    insn_id_t  id;
    vaddr_t    addr;
    vec_word_t wdata;
    vec_strb_t be;
    // Final word of its instruction
    logic      last;
  } result_t;

endpackage

`default_nettype wire

// File: slide_insn_queue.sv
// Circular queue of slide requests, hands them to the engine and reports them done
`timescale 1ns/1ps
`default_nettype none

`include "slide_consts.svh"

module slide_insn_queue import slide_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Sequencer side
  input  logic       req_valid_i,
  input  slide_req_t req_i,
  output logic       req_ready_o,
  // Engine side
  output logic       issue_valid_o,
  output slide_req_t issue_req_o,
  input  logic       issue_ready_i,
  // Last word of the oldest instruction has left the result queue
  input  logic       commit_i,
  output logic       done_o,
  output insn_id_t   done_id_o
);

  localparam int unsigned DEPTH = `SLIDE_INSN_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  // Request storage
  slide_req_t mem_q [DEPTH];

  // One pointer per phase of an instruction
  ptr_t accept_pnt_q;
  ptr_t issue_pnt_q;
  ptr_t commit_pnt_q;

  // Entries still waiting to be issued, and to be committed
  cnt_t issue_cnt_q;
  cnt_t commit_cnt_q;

  logic accept;
  logic issue_done;

  function automatic ptr_t ptr_inc(ptr_t p);
    if (p == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Full only when every slot holds an uncommitted instruction
  assign req_ready_o = (commit_cnt_q < cnt_t'(DEPTH));
  assign accept      = req_valid_i && req_ready_o;

  // Oldest unissued request goes straight out of the storage
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_req_o   = mem_q[issue_pnt_q];
  assign issue_done    = issue_valid_o && issue_ready_i;

  ////////////////////////////////////////
  // Pointers and counters
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_o       <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= ptr_inc(accept_pnt_q);
      end
      // Engine wrote its last word for this one
      if (issue_done) begin
        issue_pnt_q <= ptr_inc(issue_pnt_q);
      end
      if (commit_i) begin
        commit_pnt_q <= ptr_inc(commit_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_i);
      // Done trails the commit by one cycle
      done_o       <= commit_i;
    end
  end

  // Storage write and done tag
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= req_i;
    end
    if (commit_i) begin
      done_id_o <= mem_q[commit_pnt_q].id;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Result queue never commits an instruction that was not accepted
  a_commit_in_flight : assert property (
    @(posedge clk_i) disable iff (!rst_ni) commit_i |-> commit_cnt_q != '0
  ) else $error("commit pulse with no instruction in flight");

  // Engine only finishes what it was handed
  a_issue_ready_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_ready_i |-> issue_valid_o
  ) else $error("engine finished an instruction that was never issued");

endmodule

`default_nettype wire

// File: slide_engine.sv
// Slide engine FSM, moves bytes from operand words into destination words for the result queue
`timescale 1ns/1ps
`default_nettype none

`include "slide_consts.svh"

module slide_engine import slide_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Instruction queue side
  input  logic       issue_valid_i,
  input  slide_req_t issue_req_i,
  output logic       issue_ready_o,
  // Source words from the lanes
  input  logic       operand_valid_i,
  input  vec_word_t  operand_i,
  output logic       operand_ready_o,
  // Result queue side
  output logic       push_valid_o,
  output result_t    push_data_o,
  input  logic       push_ready_i
);

  localparam int unsigned WORD_BYTES = `SLIDE_NR_LANES * `SLIDE_LANE_BYTES;
  localparam int unsigned WORD_BITS  = 8 * WORD_BYTES;
  // Byte position inside a word and a pointer that also holds WORD_BYTES
  localparam int unsigned ROT_W      = $clog2(WORD_BYTES);
  localparam int unsigned PNT_W      = ROT_W + 1;

  typedef enum logic {
    SLIDE_IDLE,
    SLIDE_RUN
  } slide_state_e;

  typedef logic [PNT_W-1:0] pnt_t;

  slide_state_e state_q;

  // Next byte to read from the operand, next byte to fill in the result
  pnt_t      in_pnt_q;
  pnt_t      out_pnt_q;
  // Register file word being built
  vaddr_t    vrf_pnt_q;
  // Bytes still to be moved for this instruction
  byte_cnt_t cnt_q;

  // Partly built destination word
  logic [WORD_BITS-1:0]  word_q;
  logic [WORD_BYTES-1:0] be_q;

  byte_cnt_t off;
  byte_cnt_t vl_bytes;

  pnt_t      in_gap;
  pnt_t      out_gap;
  pnt_t      gap;
  byte_cnt_t step;
  logic      last_step;
  pnt_t      in_nxt;
  pnt_t      out_nxt;
  logic      consume;
  logic      push_word;
  logic      fire;

  logic [ROT_W-1:0]       rot;
  logic [2*WORD_BITS-1:0] opnd_dbl;
  logic [WORD_BITS-1:0]   opnd_rot;
  logic [WORD_BITS-1:0]   word_nxt;
  logic [WORD_BYTES-1:0]  be_nxt;

  // Slide offset and vector length in bytes
  assign off      = issue_req_i.stride << issue_req_i.sew;
  assign vl_bytes = issue_req_i.vl << issue_req_i.sew;

  ////////////////////////////////////////
  // Byte mover
  ////////////////////////////////////////

  // Room left in the operand word and in the destination word
  assign in_gap    = pnt_t'(WORD_BYTES) - in_pnt_q;
  assign out_gap   = pnt_t'(WORD_BYTES) - out_pnt_q;
  assign gap       = (in_gap < out_gap) ? in_gap : out_gap;
  // Count runs out within this step
  assign last_step = (cnt_q <= byte_cnt_t'(gap));
  assign step      = last_step ? cnt_q : byte_cnt_t'(gap);

  assign in_nxt    = in_pnt_q + pnt_t'(step);
  assign out_nxt   = out_pnt_q + pnt_t'(step);
  assign consume   = (in_nxt == pnt_t'(WORD_BYTES)) || last_step;
  assign push_word = (out_nxt == pnt_t'(WORD_BYTES)) || last_step;

  // Stall on a missing operand or a full result queue
  assign fire = (state_q == SLIDE_RUN) && operand_valid_i && push_ready_i;

  // Rotate the operand so that its byte in_pnt lands on byte out_pnt
  assign rot      = in_pnt_q[ROT_W-1:0] - out_pnt_q[ROT_W-1:0];
  assign opnd_dbl = {operand_i, operand_i} >> (8 * rot);
  assign opnd_rot = opnd_dbl[WORD_BITS-1:0];

  // Merge the copied window into the word under construction
  always_comb begin
    word_nxt = word_q;
    be_nxt   = be_q;
    for (int o = 0; o < WORD_BYTES; o++) begin
      if (o >= int'(out_pnt_q) && o < int'(out_pnt_q) + int'(step)) begin
        word_nxt[8*o +: 8] = opnd_rot[8*o +: 8];
        be_nxt[o]          = 1'b1;
      end
    end
  end

  assign operand_ready_o = fire && consume;
  assign push_valid_o    = fire && push_word;
  assign issue_ready_o   = fire && last_step;

  assign push_data_o = '{
    id:    issue_req_i.id,
    addr:  vrf_pnt_q,
    wdata: vec_word_t'(word_nxt),
    be:    vec_strb_t'(be_nxt),
    last:  last_step
  };

  ////////////////////////////////////////
  // Slide FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= SLIDE_IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      vrf_pnt_q <= '0;
      cnt_q     <= '0;
      be_q      <= '0;
    end else begin
      case (state_q)
        SLIDE_IDLE: begin
          if (issue_valid_i) begin
            state_q <= SLIDE_RUN;
            be_q    <= '0;
            if (issue_req_i.op == VSLIDEUP) begin
              // Read from word 0, write from the middle of the destination
              in_pnt_q  <= '0;
              out_pnt_q <= pnt_t'(off[ROT_W-1:0]);
              vrf_pnt_q <= issue_req_i.vd + vaddr_t'(off >> ROT_W);
              // Bytes below the offset stay untouched
              cnt_q     <= vl_bytes - off;
            end else begin
              // Read from the offset, write from byte 0
              in_pnt_q  <= pnt_t'(off[ROT_W-1:0]);
              out_pnt_q <= '0;
              vrf_pnt_q <= issue_req_i.vd;
              cnt_q     <= vl_bytes;
            end
          end
        end
        SLIDE_RUN: begin
          if (fire) begin
            in_pnt_q  <= consume ? '0 : in_nxt;
            out_pnt_q <= push_word ? '0 : out_nxt;
            cnt_q     <= cnt_q - step;
            if (push_word) begin
              // Next word starts empty at the next address
              vrf_pnt_q <= vrf_pnt_q + 1'b1;
              be_q      <= '0;
            end else begin
              be_q <= be_nxt;
            end
            if (last_step) begin
              state_q <= SLIDE_IDLE;
            end
          end
        end
      endcase
    end
  end

  // Data bytes of the open destination word
  always_ff @(posedge clk_i) begin
    if (fire && !push_word) begin
      word_q <= word_nxt;
    end
  end

  // Operands are only taken for an instruction the queue still offers
  a_operand_in_run : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    operand_ready_o |-> (state_q == SLIDE_RUN) && issue_valid_i
  ) else $error("operand taken outside of a running slide");

endmodule

`default_nettype wire

// File: slide_result_queue.sv
// Result buffer of the slide unit, holds destination words until every lane grants them
`timescale 1ns/1ps
`default_nettype none

`include "slide_consts.svh"

module slide_result_queue import slide_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Engine side
  input  logic                       push_valid_i,
  input  result_t                    push_data_i,
  output logic                       push_ready_o,
  // Register file side, one handshake per lane
  output logic [`SLIDE_NR_LANES-1:0] result_valid_o,
  input  logic [`SLIDE_NR_LANES-1:0] result_ready_i,
  output result_t                    result_o,
  // Final word of an instruction retired
  output logic                       commit_o
);

  localparam int unsigned DEPTH = `SLIDE_RESULT_DEPTH;
  localparam int unsigned LANES = `SLIDE_NR_LANES;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  result_t mem_q [DEPTH];

  // Lanes that still have to take each entry
  logic [DEPTH-1:0][LANES-1:0] lane_valid_q;

  ptr_t rd_pnt_q;
  ptr_t wr_pnt_q;
  cnt_t cnt_q;

  logic             push;
  logic             retire;
  logic [LANES-1:0] head_left;

  function automatic ptr_t ptr_inc(ptr_t p);
    if (p == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign push_ready_o = (cnt_q != cnt_t'(DEPTH));
  assign push         = push_valid_i && push_ready_o;

  // Head entry is shared by all lanes, each lane sees its own valid
  assign result_valid_o = lane_valid_q[rd_pnt_q];
  assign result_o       = mem_q[rd_pnt_q];

  // Lanes still pending after this cycle's grants
  assign head_left = lane_valid_q[rd_pnt_q] & ~result_ready_i;
  assign retire    = (cnt_q != '0) && (head_left == '0);
  assign commit_o  = retire && mem_q[rd_pnt_q].last;

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_valid_q <= '0;
      rd_pnt_q     <= '0;
      wr_pnt_q     <= '0;
      cnt_q        <= '0;
    end else begin
      // Granted lanes drop out of the head
      lane_valid_q[rd_pnt_q] <= head_left;
      // A push into an empty queue overrides the clear above
      if (push) begin
        lane_valid_q[wr_pnt_q] <= '1;
        wr_pnt_q               <= ptr_inc(wr_pnt_q);
      end
      if (retire) begin
        rd_pnt_q <= ptr_inc(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(retire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= push_data_i;
    end
  end

  // Engine must stall while the buffer is full
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_valid_i |-> push_ready_o
  ) else $error("push into a full result queue");

endmodule

`default_nettype wire

// File: slide_unit.sv
// Top level of the slide unit, wires the instruction queue, the engine and the result queue
`timescale 1ns/1ps
`default_nettype none

`include "slide_consts.svh"

module slide_unit import slide_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Requests from the sequencer
  input  logic                       req_valid_i,
  input  slide_req_t                 req_i,
  output logic                       req_ready_o,
  // Source words from the lanes
  input  logic                       operand_valid_i,
  input  vec_word_t                  operand_i,
  output logic                       operand_ready_o,
  // Writes toward the register file
  output logic [`SLIDE_NR_LANES-1:0] result_valid_o,
  input  logic [`SLIDE_NR_LANES-1:0] result_ready_i,
  output result_t                    result_o,
  // Completion back to the sequencer
  output logic                       done_o,
  output insn_id_t                   done_id_o
);

  ////////////////////////////////////////
  // Internal handshakes
  ////////////////////////////////////////

  logic       issue_valid;
  slide_req_t issue_req;
  logic       issue_ready;

  logic       push_valid;
  result_t    push_data;
  logic       push_ready;

  logic       commit;

  slide_insn_queue u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .issue_valid_o (issue_valid),
    .issue_req_o   (issue_req),
    .issue_ready_i (issue_ready),
    .commit_i      (commit),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  slide_engine u_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_valid_i   (issue_valid),
    .issue_req_i     (issue_req),
    .issue_ready_o   (issue_ready),
    .operand_valid_i (operand_valid_i),
    .operand_i       (operand_i),
    .operand_ready_o (operand_ready_o),
    .push_valid_o    (push_valid),
    .push_data_o     (push_data),
    .push_ready_i    (push_ready)
  );

  slide_result_queue u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_valid_i   (push_valid),
    .push_data_i    (push_data),
    .push_ready_o   (push_ready),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .commit_o       (commit)
  );

endmodule

`default_nettype wire

// File: slide_checker.sv
// Testbench checker of the slide unit, predicts result words and done pulses from the test data
`timescale 1ns/1ps
`default_nettype none

`include "slide_consts.svh"

module slide_checker import slide_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_ready_i,
  input  logic [`SLIDE_NR_LANES-1:0] result_valid_i,
  input  logic [`SLIDE_NR_LANES-1:0] result_ready_i,
  input  result_t                    result_i,
  input  logic                       done_i,
  input  insn_id_t                   done_id_i,
  output int                         err_cnt_o,
  output int                         done_cnt_o,
  output logic                       lanes_ok_o,
  output logic                       full_seen_o
);

  localparam int LANES = `SLIDE_NR_LANES;

  logic [31:0] td [7*32];
  logic [7:0]  src [256];
  // Expected words in register file order, ids in request order
  result_t     exp_q [$];
  insn_id_t    exp_id [$];
  // Word count up to and including each instruction
  int          word_end [$];
  int          lane_idx [LANES];
  int          n_insn;
  int          n_words;
  int          err_cnt;
  logic        full_seen;

  assign err_cnt_o   = err_cnt;
  assign full_seen_o = full_seen;

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////
  // Expected words of one instruction
  ////////////////////////////////////////

  task automatic predict_insn(input int k);
    logic [31:0]  s;
    logic [255:0] data;
    logic [31:0]  be;
    result_t      e;
    logic         up;
    int           off;
    int           vl_b;
    int           lo;
    int           i;
    s = td[7*k+6] ^ 32'he1ca;
    for (int j = 0; j < 256; j++) begin
      s = lcg_step(s);
      src[j] = s[7:0];
    end
    up   = (td[7*k][0] == 1'b0);
    off  = int'(td[7*k+3][8:0]) << td[7*k+1][1:0];
    vl_b = int'(td[7*k+2][8:0]) << td[7*k+1][1:0];
    // Slideup leaves the bytes below the offset alone
    lo   = up ? off : 0;
    for (int w = lo / 32; w <= (vl_b - 1) / 32; w++) begin
      data = '0;
      be   = '0;
      for (int b = 0; b < 32; b++) begin
        i = 32 * w + b;
        if (i >= lo && i < vl_b) begin
          data[8*b +: 8] = up ? src[i - off] : src[i + off];
          be[b]          = 1'b1;
        end
      end
      e.id    = td[7*k+5][2:0];
      e.addr  = td[7*k+4][7:0] + 8'(w);
      e.wdata = data;
      e.be    = be;
      e.last  = (w == (vl_b - 1) / 32);
      exp_q.push_back(e);
    end
    exp_id.push_back(td[7*k+5][2:0]);
    word_end.push_back(exp_q.size());
  endtask

  initial begin
    err_cnt    = 0;
    done_cnt_o <= 0;
    full_seen  = 1'b0;
    n_insn     = 0;
    for (int l = 0; l < LANES; l++) begin
      lane_idx[l] = 0;
    end
    for (int a = 0; a < 7 * 32; a++) begin
      td[a] = '1;
    end
    $readmemh("slide_testdata.txt", td);
    while (n_insn < 32 && td[7*n_insn] != 32'hffff_ffff) begin
      predict_insn(n_insn);
      n_insn++;
    end
    n_words = exp_q.size();
  end

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  // Compare one lane's share of the head word against the next expected word
  task automatic check_lane(input int l);
    result_t     e;
    logic [63:0] mask;
    if (lane_idx[l] >= n_words) begin
      report_error($sformatf("lane %0d took an extra word at addr %h", l, result_i.addr));
    end else begin
      e = exp_q[lane_idx[l]];
      for (int b = 0; b < 8; b++) begin
        mask[8*b +: 8] = {8{e.be[l][b]}};
      end
      if (result_i.id != e.id || result_i.addr != e.addr || result_i.last != e.last) begin
        report_error($sformatf("lane %0d word %0d got id %0d addr %h last %b, expected %0d %h %b",
                               l, lane_idx[l], result_i.id, result_i.addr, result_i.last,
                               e.id, e.addr, e.last));
      end
      if (result_i.be[l] != e.be[l]) begin
        report_error($sformatf("lane %0d word %0d be %h, expected %h",
                               l, lane_idx[l], result_i.be[l], e.be[l]));
      end
      if ((result_i.wdata[l] & mask) != (e.wdata[l] & mask)) begin
        report_error($sformatf("lane %0d word %0d data %h, expected %h", l, lane_idx[l],
                               result_i.wdata[l] & mask, e.wdata[l] & mask));
      end
    end
    lane_idx[l]++;
  endtask

  task automatic check_done();
    if (done_cnt_o >= n_insn) begin
      report_error($sformatf("done pulse for id %0d with no instruction left", done_id_i));
    end else begin
      if (done_id_i != exp_id[done_cnt_o]) begin
        report_error($sformatf("done id %0d, expected %0d", done_id_i, exp_id[done_cnt_o]));
      end
      // Every lane must already hold the last word
      for (int l = 0; l < LANES; l++) begin
        if (lane_idx[l] < word_end[done_cnt_o]) begin
          report_error($sformatf("done for instruction %0d before lane %0d took its words",
                                 done_cnt_o, l));
        end
      end
    end
    done_cnt_o <= done_cnt_o + 1;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (!req_ready_i) begin
        full_seen = 1'b1;
      end
      for (int l = 0; l < LANES; l++) begin
        if (result_valid_i[l] && result_ready_i[l]) begin
          check_lane(l);
        end
      end
      if (done_i) begin
        check_done();
      end
    end
  end

  always_comb begin
    lanes_ok_o = 1'b1;
    for (int l = 0; l < LANES; l++) begin
      if (lane_idx[l] != n_words) begin
        lanes_ok_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_slide_unit.sv
// Testbench top of the slide unit, drives requests, operands and grants from the test data file
`timescale 1ns/1ps
`default_nettype none

`include "slide_consts.svh"

module tb_slide_unit import slide_pkg::*; ();

  localparam int LANES      = `SLIDE_NR_LANES;
  localparam int WAIT_LIMIT = 4000;
  localparam int RUN_LIMIT  = 40000;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                req_valid;
  slide_req_t          req;
  logic                req_ready;
  logic                operand_valid;
  vec_word_t           operand;
  logic                operand_ready;
  logic [LANES-1:0]    result_valid;
  logic [LANES-1:0]    result_ready;
  result_t             result;
  logic                done;
  insn_id_t            done_id;

  logic [31:0] td [7*32];
  logic [7:0]  src [256];
  int          n_insn;
  int          tb_err;
  int          chk_err;
  int          done_cnt;
  logic        lanes_ok;
  logic        full_seen;

  // 4 ns clock
  always #2 clk = ~clk;

  slide_unit u_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .operand_valid_i (operand_valid),
    .operand_i       (operand),
    .operand_ready_o (operand_ready),
    .result_valid_o  (result_valid),
    .result_ready_i  (result_ready),
    .result_o        (result),
    .done_o          (done),
    .done_id_o       (done_id)
  );

  slide_checker u_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_ready_i    (req_ready),
    .result_valid_i (result_valid),
    .result_ready_i (result_ready),
    .result_i       (result),
    .done_i         (done),
    .done_id_i      (done_id),
    .err_cnt_o      (chk_err),
    .done_cnt_o     (done_cnt),
    .lanes_ok_o     (lanes_ok),
    .full_seen_o    (full_seen)
  );

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Source vector of instruction k, one LCG step per byte
  task automatic fill_source(input int k);
    logic [31:0] s;
    s = td[7*k+6] ^ 32'he1ca;
    for (int j = 0; j < 256; j++) begin
      s = lcg_step(s);
      src[j] = s[7:0];
    end
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic drive_requests();
    int   cycles;
    logic got;
    for (int k = 0; k < n_insn; k++) begin
      req_valid = 1'b1;
      req = '{id: td[7*k+5][2:0], op: slide_op_e'(td[7*k][0]), sew: sew_e'(td[7*k+1][1:0]),
              vl: td[7*k+2][8:0], stride: td[7*k+3][8:0], vd: td[7*k+4][7:0]};
      got    = 1'b0;
      cycles = 0;
      while (!got && cycles < WAIT_LIMIT) begin
        @(posedge clk);
        got = req_ready;
        cycles++;
      end
      if (!got) begin
        $display("Timeout: request %0d was never accepted", k);
        tb_err++;
        return;
      end
      #1;
    end
    req_valid = 1'b0;
  endtask

  // Lanes present the source words an instruction reads, in order
  task automatic drive_operands();
    int           cycles;
    int           first;
    int           nwords;
    int           off;
    int           vl_b;
    logic         got;
    logic [255:0] flat;
    for (int k = 0; k < n_insn; k++) begin
      fill_source(k);
      off  = int'(td[7*k+3][8:0]) << td[7*k+1][1:0];
      vl_b = int'(td[7*k+2][8:0]) << td[7*k+1][1:0];
      if (td[7*k][0] == 1'b0) begin
        first  = 0;
        nwords = (vl_b - off - 1) / 32 + 1;
      end else begin
        first  = off / 32;
        nwords = (off + vl_b - 1) / 32 - first + 1;
      end
      for (int w = first; w < first + nwords; w++) begin
        for (int b = 0; b < 32; b++) begin
          flat[8*b +: 8] = src[32*w + b];
        end
        operand_valid = 1'b1;
        operand       = flat;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < WAIT_LIMIT) begin
          @(posedge clk);
          got = operand_ready;
          cycles++;
        end
        if (!got) begin
          $display("Timeout: operand word %0d of instruction %0d was never taken", w, k);
          tb_err++;
          return;
        end
        #1;
      end
    end
    operand_valid = 1'b0;
  endtask

  // Each lane withholds its grant on about one cycle in four
  task automatic drive_grants();
    logic [31:0] s;
    s = 32'he1ca;
    forever begin
      @(posedge clk);
      #1;
      s = lcg_step(s);
      for (int l = 0; l < LANES; l++) begin
        result_ready[l] = (s[16+2*l +: 2] != 2'b00);
      end
    end
  endtask

  initial begin
    int cycles;
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    operand_valid = 1'b0;
    operand       = '0;
    result_ready  = '0;
    tb_err        = 0;
    n_insn        = 0;
    for (int a = 0; a < 7 * 32; a++) begin
      td[a] = '1;
    end
    $readmemh("slide_testdata.txt", td);
    while (n_insn < 32 && td[7*n_insn] != 32'hffff_ffff) begin
      n_insn++;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fork
      drive_requests();
      drive_operands();
      drive_grants();
    join_none
    cycles = 0;
    while (done_cnt != n_insn && cycles < RUN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (done_cnt != n_insn) begin
      $display("Timeout: only %0d of %0d instructions reported done", done_cnt, n_insn);
      tb_err++;
    end
    // Window for stray words or done pulses
    repeat (20) @(posedge clk);
    if (!lanes_ok) begin
      $display("Not every lane took every result word exactly once");
      tb_err++;
    end
    if (!full_seen) begin
      $display("The request queue never filled up");
      tb_err++;
    end
    $display("Checker errors: %0d, testbench errors: %0d", chk_err, tb_err);
    if (chk_err == 0 && tb_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: slide_testdata.txt
// Columns, all hex: op sew vl stride vd id seed
// op 0 is vslideup and 1 is vslidedown, vl and stride count elements of width 8 << sew bits
0 0 20  3  00 0 1234
1 0 20  5  08 1 beef
0 1 40  11 10 2 0042
1 2 20  3  20 3 0a0a
0 3 20  1  30 4 5555
1 3 10  10 40 5 7777
0 0 100 e1 50 6 0001
1 0 1   0  60 7 ffff
0 2 7   0  68 0 3c3c
1 1 55  2b 70 1 9001
0 1 7f  40 80 2 abcd
1 2 9   1  90 3 0ff0
0 0 21  20 a0 4 1111
1 0 3f  1f b0 5 2222

// File: vlog.f
+incdir+.
slide_pkg.sv
slide_insn_queue.sv
slide_engine.sv
slide_result_queue.sv
slide_unit.sv
slide_checker.sv
tb_slide_unit.sv

// File: run.sh
#!/bin/sh
rm -f sim.log && \
verilator --binary --timing --assert -f vlog.f --top-module tb_slide_unit -o tb_slide_unit && \
./obj_dir/tb_slide_unit | tee sim.log && \
grep -qx "Finished with no errors" sim.log && \
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
